// ==== ntm_fixed_pkg.sv ====
package ntm_fixed_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////////

  // Signed fixed-point operand and result
  // Binary point set by FRAC_BITS at the top level
  typedef logic signed [15:0] fixed_t;

  // Full-precision product before rounding and scaling
  typedef logic signed [31:0] product_t;

  // Matrix size or index, sizes 1 to 255
  typedef logic [7:0] dim_t;

  ////////////////////////////////////////////////////////////////////////////
  // Control types
  ////////////////////////////////////////////////////////////////////////////

  // Dispatcher FSM
  typedef enum logic [1:0] {
    ST_IDLE,    // waiting for start
    ST_STREAM,  // taking A/B pairs
    ST_DRAIN    // all pairs taken, waiting for credits to come home
  } dispatch_state_e;

endpackage

// ==== ntm_fixed_mul_lane.sv ====
`timescale 1ns/100ps

module ntm_fixed_mul_lane
  import ntm_fixed_pkg::*;
#(
  parameter int LANE_DEPTH = 4,
  parameter int FRAC_BITS  = 8
) (
  input  logic   CLK,
  input  logic   RST,
  input  logic   push,
  input  fixed_t a,
  input  fixed_t b,
  input  logic   row_end,
  input  logic   last,
  input  logic   pop,
  output logic   nonempty,
  output fixed_t data,
  output logic   row_end_q,
  output logic   last_q
);

  localparam int AW = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
  localparam int CW = $clog2(LANE_DEPTH + 1);

  // Half an output LSB for round half up
  localparam product_t HALF_LSB = product_t'((2 ** FRAC_BITS) / 2);
  localparam fixed_t   FIX_MAX  = {1'b0, {($bits(fixed_t) - 1){1'b1}}};
  localparam fixed_t   FIX_MIN  = {1'b1, {($bits(fixed_t) - 1){1'b0}}};

  logic          mul_valid;
  product_t      mul_prod;
  logic          mul_row_end;
  logic          mul_last;
  product_t      prod_round;
  product_t      prod_shift;
  fixed_t        prod_sat;
  fixed_t        mem_data    [LANE_DEPTH];
  logic          mem_row_end [LANE_DEPTH];
  logic          mem_last    [LANE_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  ////////////////////////////////////////////////////////////////////////////
  // Multiply stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mul_valid <= 1'b0;
    end else begin
      mul_valid <= push;
    end
  end

  // Full 32-bit signed product with its tags
  always_ff @(posedge CLK) begin
    if (push) begin
      mul_prod    <= product_t'(a) * product_t'(b);
      mul_row_end <= row_end;
      mul_last    <= last;
    end
  end

  // Round, scale back by FRAC_BITS, clamp to fixed_t
  always_comb begin
    prod_round = mul_prod + HALF_LSB;
    prod_shift = prod_round >>> FRAC_BITS;
    if (prod_shift > product_t'(FIX_MAX)) begin
      prod_sat = FIX_MAX;
    end else if (prod_shift < product_t'(FIX_MIN)) begin
      prod_sat = FIX_MIN;
    end else begin
      prod_sat = fixed_t'(prod_shift);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result FIFO
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (mul_valid) begin
      mem_data[wr_ptr]    <= prod_sat;
      mem_row_end[wr_ptr] <= mul_row_end;
      mem_last[wr_ptr]    <= mul_last;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (mul_valid) begin
        wr_ptr <= (wr_ptr == AW'(LANE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(LANE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(mul_valid) - CW'(pop);
    end
  end

  // Show-ahead read
  assign nonempty  = (count != '0);
  assign data      = mem_data[rd_ptr];
  assign row_end_q = mem_row_end[rd_ptr];
  assign last_q    = mem_last[rd_ptr];

  // Dispatcher credits keep the FIFO from overflowing
  a_no_overflow: assert property (@(posedge CLK) disable iff (RST)
    mul_valid |-> (count != CW'(LANE_DEPTH)));
  a_no_underflow: assert property (@(posedge CLK) disable iff (RST)
    pop |-> nonempty);

endmodule

// ==== ntm_matrix_dispatch.sv ====
`timescale 1ns/100ps

module ntm_matrix_dispatch
  import ntm_fixed_pkg::*;
#(
  parameter int LANES      = 4,
  parameter int LANE_DEPTH = 4
) (
  input  logic             CLK,
  input  logic             RST,
  input  logic             start,
  input  dim_t             size_i,
  input  dim_t             size_j,
  input  logic             in_enable,
  input  fixed_t           data_a,
  input  fixed_t           data_b,
  input  logic [LANES-1:0] credit_return,
  output logic             busy,
  output logic             in_ready,
  output logic [LANES-1:0] lane_push,
  output fixed_t           lane_a,
  output fixed_t           lane_b,
  output logic             lane_row_end,
  output logic             lane_last
);

  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;
  localparam int CNT_W = $clog2(LANE_DEPTH + 1);

  dispatch_state_e  state;
  dim_t             size_i_q;
  dim_t             size_j_q;
  dim_t             idx_i;
  dim_t             idx_j;
  logic [PTR_W-1:0] lane_ptr;
  logic [CNT_W-1:0] credit      [LANES];
  logic [CNT_W-1:0] credit_next [LANES];
  logic             take;
  logic             all_home;

  ////////////////////////////////////////////////////////////////////////////
  // Input handshake and lane selection
  ////////////////////////////////////////////////////////////////////////////

  assign busy     = (state != ST_IDLE);
  assign in_ready = (state == ST_STREAM) && (credit[lane_ptr] != '0);
  assign take     = in_enable && in_ready;

  // Operands go straight onto the shared lane buses
  assign lane_a = data_a;
  assign lane_b = data_b;

  // Tags from the current indices
  assign lane_row_end = (idx_j == dim_t'(size_j_q - 1'b1));
  assign lane_last    = lane_row_end && (idx_i == dim_t'(size_i_q - 1'b1));

  always_comb begin
    all_home = 1'b1;
    for (int k = 0; k < LANES; k++) begin
      // One-hot push to the lane under the pointer
      lane_push[k]   = take && (lane_ptr == PTR_W'(k));
      // Push and return may coincide
      credit_next[k] = credit[k] - CNT_W'(lane_push[k]) + CNT_W'(credit_return[k]);
      if (credit_next[k] != CNT_W'(LANE_DEPTH)) begin
        all_home = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM and index walker
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ST_IDLE;
      idx_i    <= '0;
      idx_j    <= '0;
      lane_ptr <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            idx_i <= '0;
            idx_j <= '0;
            state <= ST_STREAM;
          end
        end
        ST_STREAM: begin
          if (take) begin
            if (lane_last) begin
              state <= ST_DRAIN;
            end else if (lane_row_end) begin
              idx_i <= idx_i + 1'b1;
              idx_j <= '0;
            end else begin
              idx_j <= idx_j + 1'b1;
            end
          end
        end
        // Leave once the credit of the last pair is back
        ST_DRAIN: begin
          if (all_home) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
      // Round robin over lanes, kept across matrices
      if (take) begin
        lane_ptr <= (lane_ptr == PTR_W'(LANES - 1)) ? '0 : lane_ptr + 1'b1;
      end
    end
  end

  // Sizes held for the whole matrix
  always_ff @(posedge CLK) begin
    if ((state == ST_IDLE) && start) begin
      size_i_q <= size_i;
      size_j_q <= size_j;
    end
  end

  // Credit counters, full after reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int k = 0; k < LANES; k++) begin
        credit[k] <= CNT_W'(LANE_DEPTH);
      end
    end else begin
      for (int k = 0; k < LANES; k++) begin
        credit[k] <= credit_next[k];
      end
    end
  end

  // Credit checks per lane
  for (genvar k = 0; k < LANES; k++) begin : g_credit_chk
    a_push_needs_credit: assert property (@(posedge CLK) disable iff (RST)
      lane_push[k] |-> (credit[k] != '0));
    // Collector never returns more than was pushed
    a_credit_bound: assert property (@(posedge CLK) disable iff (RST)
      credit[k] <= CNT_W'(LANE_DEPTH));
  end

endmodule

// ==== ntm_matrix_collect.sv ====
`timescale 1ns/100ps

module ntm_matrix_collect
  import ntm_fixed_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic             CLK,
  input  logic             RST,
  input  logic [LANES-1:0] lane_nonempty,
  input  fixed_t           lane_data [LANES],
  input  logic [LANES-1:0] lane_row_end_q,
  input  logic [LANES-1:0] lane_last_q,
  input  logic             out_ready,
  output logic [LANES-1:0] lane_pop,
  output logic [LANES-1:0] credit_return,
  output logic             out_enable,
  output fixed_t           out_data,
  output logic             out_row_end,
  output logic             out_last
);

  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [PTR_W-1:0] lane_ptr;
  logic [PTR_W-1:0] out_src;
  logic             out_free;
  logic             out_taken;
  logic             pop_now;

  ////////////////////////////////////////////////////////////////////////////
  // Pop and credit decode
  ////////////////////////////////////////////////////////////////////////////

  assign out_taken = out_enable && out_ready;
  // Output register empty or leaving this cycle
  assign out_free  = !out_enable || out_ready;
  // Wait on the lane in order, never skip ahead
  assign pop_now   = lane_nonempty[lane_ptr] && out_free;

  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      lane_pop[k]      = pop_now && (lane_ptr == PTR_W'(k));
      // Credit goes home when the entry leaves the output register
      credit_return[k] = out_taken && (out_src == PTR_W'(k));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_enable <= 1'b0;
      lane_ptr   <= '0;
      out_src    <= '0;
    end else begin
      if (pop_now) begin
        out_enable <= 1'b1;
        out_src    <= lane_ptr;
        // Same rotation as the dispatcher
        lane_ptr   <= (lane_ptr == PTR_W'(LANES - 1)) ? '0 : lane_ptr + 1'b1;
      end else if (out_ready) begin
        out_enable <= 1'b0;
      end
    end
  end

  // Result and tags
  always_ff @(posedge CLK) begin
    if (pop_now) begin
      out_data    <= lane_data[lane_ptr];
      out_row_end <= lane_row_end_q[lane_ptr];
      out_last    <= lane_last_q[lane_ptr];
    end
  end

  // Held output stays put until the sink takes it
  a_out_hold: assert property (@(posedge CLK) disable iff (RST)
    (out_enable && !out_ready) |=> (out_enable && $stable(out_data)
      && $stable(out_row_end) && $stable(out_last)));

endmodule

// ==== ntm_matrix_fixed_multiplier.sv ====
`timescale 1ns/100ps

module ntm_matrix_fixed_multiplier
  import ntm_fixed_pkg::*;
#(
  parameter int LANES      = 4,
  parameter int LANE_DEPTH = 4,
  parameter int FRAC_BITS  = 8
) (
  input  logic   CLK,
  input  logic   RST,
  input  logic   start,
  input  dim_t   size_i,
  input  dim_t   size_j,
  input  logic   in_enable,
  input  fixed_t data_a,
  input  fixed_t data_b,
  input  logic   out_ready,
  output logic   busy,
  output logic   in_ready,
  output logic   out_enable,
  output fixed_t out_data,
  output logic   out_row_end,
  output logic   out_last
);

  // Dispatcher to lanes
  logic [LANES-1:0] lane_push;
  fixed_t           lane_a;
  fixed_t           lane_b;
  logic             lane_row_end;
  logic             lane_last;

  // Lanes to collector and back
  logic [LANES-1:0] lane_pop;
  logic [LANES-1:0] lane_nonempty;
  fixed_t           lane_data [LANES];
  logic [LANES-1:0] lane_row_end_q;
  logic [LANES-1:0] lane_last_q;
  logic [LANES-1:0] credit_return;

  ////////////////////////////////////////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////////////////////////////////////////

  ntm_matrix_dispatch #(
    .LANES     (LANES),
    .LANE_DEPTH(LANE_DEPTH)
  ) i_dispatch (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .size_i       (size_i),
    .size_j       (size_j),
    .in_enable    (in_enable),
    .data_a       (data_a),
    .data_b       (data_b),
    .credit_return(credit_return),
    .busy         (busy),
    .in_ready     (in_ready),
    .lane_push    (lane_push),
    .lane_a       (lane_a),
    .lane_b       (lane_b),
    .lane_row_end (lane_row_end),
    .lane_last    (lane_last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Multiplier lanes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    ntm_fixed_mul_lane #(
      .LANE_DEPTH(LANE_DEPTH),
      .FRAC_BITS (FRAC_BITS)
    ) i_lane (
      .CLK      (CLK),
      .RST      (RST),
      .push     (lane_push[k]),
      .a        (lane_a),
      .b        (lane_b),
      .row_end  (lane_row_end),
      .last     (lane_last),
      .pop      (lane_pop[k]),
      .nonempty (lane_nonempty[k]),
      .data     (lane_data[k]),
      .row_end_q(lane_row_end_q[k]),
      .last_q   (lane_last_q[k])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Collector
  ////////////////////////////////////////////////////////////////////////////

  ntm_matrix_collect #(
    .LANES(LANES)
  ) i_collect (
    .CLK           (CLK),
    .RST           (RST),
    .lane_nonempty (lane_nonempty),
    .lane_data     (lane_data),
    .lane_row_end_q(lane_row_end_q),
    .lane_last_q   (lane_last_q),
    .out_ready     (out_ready),
    .lane_pop      (lane_pop),
    .credit_return (credit_return),
    .out_enable    (out_enable),
    .out_data      (out_data),
    .out_row_end   (out_row_end),
    .out_last      (out_last)
  );

endmodule

// ==== tb_ntm_fixed_model.svh ====
`ifndef TB_NTM_FIXED_MODEL_SVH
`define TB_NTM_FIXED_MODEL_SVH

// Expected results, oldest first
fixed_t exp_data_q[$];
bit     exp_row_end_q[$];
bit     exp_last_q[$];

// Nearest multiple of 2^-FRAC_BITS with ties upward, then clamp to 16 bits
function automatic fixed_t model_product(input fixed_t a, input fixed_t b);
  longint prod;
  longint scale;
  longint sum;
  longint q;
  prod  = longint'(a) * longint'(b);
  scale = longint'(1) << FRAC_BITS;
  sum   = prod + scale / 2;
  // Floor division, negative sums too
  if (sum >= 0) begin
    q = sum / scale;
  end else begin
    q = -((-sum + scale - 1) / scale);
  end
  if (q > 32767) begin
    q = 32767;
  end else if (q < -32768) begin
    q = -32768;
  end
  return fixed_t'(q);
endfunction

// One pair with its position flags
function automatic void model_push(input fixed_t a, input fixed_t b, input bit row_end,
                                   input bit last);
  exp_data_q.push_back(model_product(a, b));
  exp_row_end_q.push_back(row_end);
  exp_last_q.push_back(last);
endfunction

`endif

// ==== tb_ntm_matrix_fixed_multiplier.sv ====
`timescale 1ns/100ps

module tb_ntm_matrix_fixed_multiplier
  import ntm_fixed_pkg::*;
;

  localparam int FRAC_BITS = 8;
  localparam int NUM_MATS  = 10;

  logic   CLK;
  logic   RST;
  logic   start;
  dim_t   size_i;
  dim_t   size_j;
  logic   in_enable;
  fixed_t data_a;
  fixed_t data_b;
  logic   out_ready;
  logic   busy;
  logic   in_ready;
  logic   out_enable;
  fixed_t out_data;
  logic   out_row_end;
  logic   out_last;

  // Per-matrix sizes, input gap and output stall percentages
  int mat_i     [NUM_MATS];
  int mat_j     [NUM_MATS];
  int mat_gap   [NUM_MATS];
  int mat_stall [NUM_MATS];
  int stall_pct       = 0;
  int watchdog_cycles = 0;

  // Monitor state
  bit     held_wait    = 1'b0;
  fixed_t held_data;
  bit     held_row_end = 1'b0;
  bit     held_last    = 1'b0;
  bit     last_done    = 1'b0;

  `include "tb_ntm_fixed_model.svh"

  ntm_matrix_fixed_multiplier i_ntm_matrix_fixed_multiplier (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .size_i     (size_i),
    .size_j     (size_j),
    .in_enable  (in_enable),
    .data_a     (data_a),
    .data_b     (data_b),
    .out_ready  (out_ready),
    .busy       (busy),
    .in_ready   (in_ready),
    .out_enable (out_enable),
    .out_data   (out_data),
    .out_row_end(out_row_end),
    .out_last   (out_last)
  );

  always #2 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Error handling and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_fixed(input string what, input fixed_t got, input fixed_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                         $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input bit got, input bit exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s got %0b expected %0b",
                         $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // One clock and a new random out_ready for the sink
  task automatic next_cycle();
    @(posedge CLK);
    out_ready <= ($urandom_range(99) >= stall_pct);
  endtask

  // Extremes often so both clamps and negative rounding get hit
  function automatic fixed_t rand_operand();
    case ($urandom_range(9))
      0:       return 16'sh7FFF;
      1:       return 16'sh8000;
      2:       return 16'sh8001;
      3, 4:    return fixed_t'(int'($urandom_range(1023)) - 512);
      default: return fixed_t'($urandom);
    endcase
  endfunction

  task automatic run_matrix(input int m);
    fixed_t a_q[$];
    fixed_t b_q[$];
    fixed_t a;
    fixed_t b;
    int     total;
    int     n;
    bit     first;
    bit     poked;
    // Previous matrix fully drained and dispatcher idle
    while (busy || (exp_data_q.size() != 0)) begin
      next_cycle();
    end
    stall_pct = mat_stall[m];
    total     = mat_i[m] * mat_j[m];
    for (int i = 0; i < mat_i[m]; i++) begin
      for (int j = 0; j < mat_j[m]; j++) begin
        a = rand_operand();
        b = rand_operand();
        a_q.push_back(a);
        b_q.push_back(b);
        model_push(a, b, (j == mat_j[m] - 1), (i == mat_i[m] - 1) && (j == mat_j[m] - 1));
      end
    end
    start  <= 1'b1;
    size_i <= dim_t'(mat_i[m]);
    size_j <= dim_t'(mat_j[m]);
    next_cycle();
    check_flag("busy before start taken", busy, 1'b0);
    start <= 1'b0;
    n     = 0;
    first = 1'b1;
    poked = 1'b0;
    while (n < total) begin
      next_cycle();
      if (first) begin
        check_flag("busy after start", busy, 1'b1);
        first = 1'b0;
      end
      if (in_enable && in_ready) begin
        n++;
      end
      start <= 1'b0;
      if (n < total) begin
        in_enable <= ($urandom_range(99) >= mat_gap[m]);
        data_a    <= a_q[n];
        data_b    <= b_q[n];
        // Stray start with other sizes in mid-matrix
        if (!poked && (n >= total / 2)) begin
          start  <= 1'b1;
          size_i <= dim_t'($urandom_range(1, 12));
          size_j <= dim_t'($urandom_range(1, 12));
          poked = 1'b1;
        end
      end else begin
        in_enable <= 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (!RST) begin
      // Waiting output must not move
      if (held_wait) begin
        check_flag("out_enable while held", out_enable, 1'b1);
        check_fixed("out_data while held", out_data, held_data);
        check_flag("out_row_end while held", out_row_end, held_row_end);
        check_flag("out_last while held", out_last, held_last);
      end
      if (!busy) begin
        check_flag("in_ready while idle", in_ready, 1'b0);
      end
      if (last_done) begin
        check_flag("busy after last output", busy, 1'b0);
      end
      last_done = 1'b0;
      if (out_enable && out_ready) begin
        if (exp_data_q.size() == 0) begin
          fail_run("output accepted while no result was expected");
        end else begin
          check_flag("busy with outputs pending", busy, 1'b1);
          check_fixed("out_data", out_data, exp_data_q.pop_front());
          check_flag("out_row_end", out_row_end, exp_row_end_q.pop_front());
          check_flag("out_last", out_last, exp_last_q.pop_front());
          last_done = out_last;
        end
      end
      held_wait    = out_enable && !out_ready;
      held_data    = out_data;
      held_row_end = out_row_end;
      held_last    = out_last;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    dispatch_state_e st;
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge CLK);
    st = i_ntm_matrix_fixed_multiplier.i_dispatch.state;
    fail_run($sformatf("timeout: run not done within %0d cycles, dispatcher in %s",
                       watchdog_cycles, st.name()));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int seed_val;
    int total_elems;
    seed_val  = $urandom(26913);
    CLK       = 1'b0;
    RST       = 1'b1;
    start     = 1'b0;
    size_i    = '0;
    size_j    = '0;
    in_enable = 1'b0;
    data_a    = '0;
    data_b    = '0;
    out_ready = 1'b0;
    // Corner sizes first and then random mixes of gaps and stalls
    mat_i[0] = 1;
    mat_j[0] = 1;
    mat_gap[0] = 0;
    mat_stall[0] = 0;
    mat_i[1] = 12;
    mat_j[1] = 12;
    mat_gap[1] = 0;
    mat_stall[1] = 0;
    mat_i[2] = 12;
    mat_j[2] = 12;
    mat_gap[2] = 30;
    mat_stall[2] = 50;
    total_elems = 1 + 144 + 144;
    for (int m = 3; m < NUM_MATS; m++) begin
      mat_i[m]     = $urandom_range(1, 12);
      mat_j[m]     = $urandom_range(1, 12);
      mat_gap[m]   = $urandom_range(0, 50);
      mat_stall[m] = $urandom_range(0, 60);
      total_elems += mat_i[m] * mat_j[m];
    end
    watchdog_cycles = total_elems * 20 + 1000;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    // Idle after reset until the first start
    repeat (3) begin
      next_cycle();
      check_flag("busy after reset", busy, 1'b0);
      check_flag("in_ready after reset", in_ready, 1'b0);
      check_flag("out_enable after reset", out_enable, 1'b0);
    end
    for (int m = 0; m < NUM_MATS; m++) begin
      run_matrix(m);
    end
    while (busy || (exp_data_q.size() != 0)) begin
      next_cycle();
    end
    stall_pct = 0;
    // Quiet tail so stray outputs would show up
    repeat (10) next_cycle();
    // DUT back to idle with nothing left in flight
    if (busy || in_ready || out_enable || (exp_data_q.size() != 0)) begin
      fail_run("DUT not idle or results still pending at end of run");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== build.f ====
+incdir+.
ntm_fixed_pkg.sv
ntm_fixed_mul_lane.sv
ntm_matrix_dispatch.sv
ntm_matrix_collect.sv
ntm_matrix_fixed_multiplier.sv
tb_ntm_matrix_fixed_multiplier.sv
